/* filelist.f */
verilog/codecPkg.sv
verilog/busPkg.sv
verilog/wbBitstreamPort.sv
verilog/expGolombDecoder.sv
verilog/cbpDecoder.sv
verilog/mbHeaderParser.sv
verilog/mbHeaderTop.sv
verification/tbMbHeader.sv

/* run.sh */
#!/bin/sh
# Builds the macroblock header testbench with Verilator, runs it and
# looks for the pass message in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbMbHeader \
	-f filelist.f --Mdir obj_dir -o simMbHeader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simMbHeader)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "Simulation reported a failure"
exit 1

/* verification/tbMbHeader.sv */
// Testbench for the macroblock header decoder
// Encodes random macroblocks as Exp-Golomb words, writes them over Wishbone
// and checks each result against a reference model

`timescale 1ns/1ps
`default_nettype none

module tbMbHeader;

	localparam int BufDepth    = 4;
	localparam int IMbs        = 200;
	localparam int PMbs        = 200;
	localparam int BpMbs       = 150;
	localparam int StallMbs    = 60;
	localparam int ErrMbs      = 17;
	localparam int PadMax      = 17;   // Filler macroblocks per test at most
	localparam int StallWindow = 100;  // Cycles the output is held off
	localparam int CycleLimit  =
		40 * (IMbs + PMbs + BpMbs + StallMbs + ErrMbs + 5 * PadMax) + 1000;

	localparam int ModeOn     = 0;
	localparam int ModeRandom = 1;
	localparam int ModeLow    = 2;

	logic                clk;
	logic                rstN;
	busPkg::wbReqT       wbReq;
	busPkg::wbRspT       wbRsp;
	codecPkg::sliceTypeT sliceType;
	codecPkg::mbHeaderT  resultData;
	logic                resultValid;
	logic                resultReady;

	integer             seed = 32'ha6c6c0c5;
	bit                 bitQ[$];
	logic [31:0]        wordQ[$];
	codecPkg::mbHeaderT expQ[$];
	codecPkg::mbHeaderT held;          // What the parser keeps between macroblocks
	codecPkg::mbHeaderT pendData;
	logic               pendValid = 1'b0;
	int                 readyMode = ModeOn;
	int                 cycles = 0;
	int                 errCount = 0;
	int                 testCount = 0;
	int                 mbCount = 0;
	int                 resultCount = 0;
	int                 ackCount = 0;
	int                 errFlagCount = 0;
	int                 wordsSent = 0;

	// Standard coded_block_pattern mapping for 4:2:0, value is chroma * 16 + luma
	int intraTab[48] = '{47, 31, 15, 0, 23, 27, 29, 30, 7, 11, 13, 14, 39, 43, 45, 46,
		16, 3, 5, 10, 12, 19, 21, 26, 28, 35, 37, 42, 44, 1, 2, 4,
		8, 17, 18, 20, 24, 6, 9, 22, 25, 32, 33, 34, 36, 40, 38, 41};
	int interTab[48] = '{0, 16, 1, 2, 4, 8, 32, 3, 5, 10, 12, 15, 47, 7, 11, 13,
		14, 6, 9, 31, 35, 37, 42, 44, 33, 34, 36, 40, 39, 43, 45, 46,
		17, 18, 20, 24, 19, 21, 26, 28, 23, 27, 29, 30, 22, 25, 38, 41};

	mbHeaderTop #(.BufDepth(BufDepth), .MaxZeros(15)) dut (
		.clk        (clk),
		.rstN       (rstN),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.sliceType  (sliceType),
		.resultData (resultData),
		.resultValid(resultValid),
		.resultReady(resultReady)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ------------------------------------------------------------------------
	// Stimulus encoding and reference model
	// ------------------------------------------------------------------------
	function automatic int randBelow(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic putCode(input int v);
		int x;
		int n;
		x = v + 1;
		n = 0;
		while ((x >> (n + 1)) != 0)
			n++;
		repeat (n)
			bitQ.push_back(1'b0);
		for (int i = n; i >= 0; i--)
			bitQ.push_back(x[i]);  // Leading one, then the suffix
	endtask

	task automatic addMb(input codecPkg::sliceTypeT s, input int mbType, input int cbpCode);
		int   intra;
		int   pattern;
		logic readCbp;
		putCode(mbType);
		held.mbType = 5'(mbType);
		held.error  = 1'b0;
		readCbp     = 1'b0;
		intra       = (s == codecPkg::sliceP) ? mbType - 5 : mbType;
		if (s == codecPkg::sliceP && mbType < 5)
		begin
			held.mbClass = codecPkg::mbInter;
			readCbp      = 1'b1;
		end
		else if (intra == 0)
		begin
			held.mbClass = codecPkg::mbIntra4x4;
			readCbp      = 1'b1;
		end
		else if (intra <= 24)
		begin
			// Pattern follows from the intra 16x16 type alone
			held.mbClass    = codecPkg::mbIntra16x16;
			held.cbp.luma   = (intra - 1 >= 12) ? 4'hF : 4'h0;
			held.cbp.chroma = 2'(((intra - 1) / 4) % 3);
		end
		else
			held.error = 1'b1;  // Class and pattern stay as they were
		if (readCbp)
		begin
			putCode(cbpCode);
			if (cbpCode > 47)
			begin
				held.error = 1'b1;
				pattern    = 2 * 16 + 15;  // Treated as fully coded
			end
			else if (held.mbClass == codecPkg::mbInter)
				pattern = interTab[cbpCode];
			else
				pattern = intraTab[cbpCode];
			held.cbp.luma   = 4'(pattern % 16);
			held.cbp.chroma = 2'(pattern / 16);
		end
		expQ.push_back(held);
		mbCount++;
	endtask

	task automatic addRandomMb(input codecPkg::sliceTypeT s);
		int t;
		if (s == codecPkg::sliceI)
			t = randBelow(2) ? 0 : 1 + randBelow(24);
		else
			t = randBelow(2) ? randBelow(5) : 5 + randBelow(25);
		addMb(s, t, randBelow(48));
	endtask

	// Fills the last word with short complete macroblocks, then packs words
	task automatic closeStream(input codecPkg::sliceTypeT s);
		int          r;
		int          oddLen;
		logic [31:0] w;
		oddLen = (s == codecPkg::sliceI) ? 3 : 5;
		r      = (32 - bitQ.size() % 32) % 32;
		while (r % 2 == 1 && r < oddLen)
			r += 32;
		if (r % 2 == 1)
		begin
			if (s == codecPkg::sliceI)
				addMb(s, 1, 0);
			else
				addMb(s, 6, 0);
			r -= oddLen;
		end
		while (r > 0)
		begin
			addMb(s, 0, 0);  // Two bits
			r -= 2;
		end
		while (bitQ.size() != 0)
		begin
			w = '0;
			for (int i = 31; i >= 0; i--)
				w[i] = bitQ.pop_front();
			wordQ.push_back(w);
		end
	endtask

	// ------------------------------------------------------------------------
	// Bus master and test control
	// ------------------------------------------------------------------------
	task automatic writeWords;
		logic [31:0] w;
		while (wordQ.size() != 0)
		begin
			w = wordQ.pop_front();
			wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: 4'(wordsSent), dat: w};
			@(posedge clk);
			while (!wbRsp.ack)
				@(posedge clk);
			wordsSent++;
		end
		wbReq <= '0;
	endtask

	task automatic checkField(input string name, input int got, input int want);
		if (got != want)
		begin
			$display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
			errCount++;
		end
	endtask

	// Wishbone read, the port answers with zero data and stores nothing
	task automatic readWord;
		wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: 4'd0, dat: 32'hFFFF_FFFF};
		@(posedge clk);
		while (!wbRsp.ack)
			@(posedge clk);
		checkField("wbRsp.dat", wbRsp.dat, 0);
		wbReq <= '0;
	endtask

	task automatic setReady(input int mode);
		@(negedge clk);
		readyMode = mode;
		@(posedge clk);
	endtask

	task automatic drainResults;
		while (expQ.size() != 0)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic endTest(input int num, input string name, input int errBase, input int mbs);
		drainResults();
		setReady(ModeOn);
		$display("Test %0d %s: %0d macroblocks, %0d errors", num, name, mbs,
			errCount - errBase);
		testCount++;
	endtask

	task automatic takeResult;
		codecPkg::mbHeaderT want;
		if (expQ.size() == 0)
		begin
			$display("Result at %0t ns arrived with no macroblock outstanding", $time);
			errCount++;
		end
		else
		begin
			want = expQ.pop_front();
			checkField("resultData.mbType", resultData.mbType, want.mbType);
			checkField("resultData.mbClass", resultData.mbClass, want.mbClass);
			checkField("resultData.cbp.luma", resultData.cbp.luma, want.cbp.luma);
			checkField("resultData.cbp.chroma", resultData.cbp.chroma, want.cbp.chroma);
			checkField("resultData.error", resultData.error, want.error);
			if (resultData.error)
				errFlagCount++;
			resultCount++;
		end
	endtask

	always @(posedge clk)
	begin
		if (readyMode == ModeRandom)
			resultReady <= 1'($random(seed));
		else
			resultReady <= (readyMode == ModeOn);
	end

	// Output monitor, values seen here are the ones the DUT sampled
	always @(posedge clk)
	begin
		if (rstN)
		begin
			if (wbRsp.ack)
				ackCount++;
			if (pendValid && (!resultValid || resultData != pendData))
			begin
				$display("Result changed at %0t ns before its transfer", $time);
				errCount++;
			end
			if (resultValid && resultReady)
				takeResult();
			pendValid = resultValid && !resultReady;
			pendData  = resultData;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CycleLimit)
		begin
			$display("Timeout after %0d cycles, %0d results still expected", cycles,
				expQ.size());
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		int errBase;
		int mbBase;
		int ackBase;
		int flagBase;
		wbReq       = '0;
		sliceType   = codecPkg::sliceI;
		resultReady = 1'b0;
		rstN        = 1'b0;
		held        = '0;

		// Reset held for 8 cycles, then idle with nothing written
		errBase = errCount;
		for (int c = 0; c < 28; c++)
		begin
			@(posedge clk);
			if (c == 7)
				rstN <= 1'b1;
			if (resultValid)
			begin
				$display("resultValid high at %0t ns before any write", $time);
				errCount++;
			end
			if (wbRsp.ack)
			begin
				$display("Ack high at %0t ns without a bus request", $time);
				errCount++;
			end
		end
		endTest(1, "reset", errBase, 0);

		errBase = errCount;
		mbBase  = mbCount;
		sliceType <= codecPkg::sliceI;
		for (int i = 0; i < IMbs; i++)
			addRandomMb(codecPkg::sliceI);
		closeStream(codecPkg::sliceI);
		writeWords();
		endTest(2, "I slice", errBase, mbCount - mbBase);

		errBase = errCount;
		mbBase  = mbCount;
		sliceType <= codecPkg::sliceP;
		for (int i = 0; i < PMbs; i++)
		begin
			if (i % 4 == 0 && i < 4 * 48)
				addMb(codecPkg::sliceP, randBelow(5), i / 4);  // Walks every pattern code
			else
				addRandomMb(codecPkg::sliceP);
		end
		closeStream(codecPkg::sliceP);
		writeWords();
		endTest(3, "P slice", errBase, mbCount - mbBase);

		errBase = errCount;
		mbBase  = mbCount;
		for (int i = 0; i < BpMbs; i++)
			addRandomMb(codecPkg::sliceP);
		closeStream(codecPkg::sliceP);
		setReady(ModeRandom);
		writeWords();
		endTest(4, "back-pressure", errBase, mbCount - mbBase);

		// Output held off so the buffer fills and the bus has to wait
		errBase = errCount;
		mbBase  = mbCount;
		sliceType <= codecPkg::sliceI;
		for (int i = 0; i < StallMbs; i++)
			addRandomMb(codecPkg::sliceI);
		closeStream(codecPkg::sliceI);
		ackBase = ackCount;
		setReady(ModeLow);
		fork
			writeWords();
			begin
				repeat (StallWindow)
					@(posedge clk);
				@(negedge clk);
				if (ackCount - ackBase != BufDepth)
				begin
					$display("Bus accepted %0d words while the buffer holds %0d",
						ackCount - ackBase, BufDepth);
					errCount++;
				end
				if (wordQ.size() == 0)
				begin
					$display("All words were accepted while the output was held");
					errCount++;
				end
				readyMode = ModeOn;
			end
		join
		endTest(5, "bus stall", errBase, mbCount - mbBase);

		errBase  = errCount;
		mbBase   = mbCount;
		flagBase = errFlagCount;
		for (int i = 0; i < 5; i++)
			addRandomMb(codecPkg::sliceI);
		addMb(codecPkg::sliceI, 25, 0);  // I_PCM
		for (int i = 0; i < 5; i++)
			addRandomMb(codecPkg::sliceI);
		addMb(codecPkg::sliceI, 0, 48);
		for (int i = 0; i < 5; i++)
			addRandomMb(codecPkg::sliceI);
		closeStream(codecPkg::sliceI);
		readWord();  // A stored read would shift the whole stream below
		writeWords();
		drainResults();
		if (errFlagCount - flagBase != 2)
		begin
			$display("Saw %0d results with the error flag where 2 were inserted",
				errFlagCount - flagBase);
			errCount++;
		end
		endTest(6, "errors", errBase, mbCount - mbBase);

		$display("Tests %0d, macroblocks %0d, results %0d, errors %0d", testCount, mbCount,
			resultCount, errCount);
		if (errCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/busPkg.sv */
// Wishbone classic bus structs
// Request from the host master and response from the slave port

`default_nettype none

package busPkg;

	typedef struct packed
	{
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat;  // Write data
	} wbReqT;

	typedef struct packed
	{
		logic        ack;
		logic [31:0] dat;  // Read data
	} wbRspT;

endpackage

`default_nettype wire

/* verilog/cbpDecoder.sv */
// Coded block pattern decoder
// Maps a coded_block_pattern code number to luma and chroma patterns
// with the inter or intra 4x4 table, registered one cycle later

`timescale 1ns/1ps
`default_nettype none

module cbpDecoder (
	input  wire logic              clk,
	input  wire logic              rstN,
	input  wire logic              cbpValid,
	input  wire logic [5:0]        cbpCode,
	input  codecPkg::mbClassT      mbClass,
	output logic                   cbpDone,
	output codecPkg::cbpT          cbp
);

	// --------------------------------------------------------------------------
	// Code number to pattern tables, 4:2:0 chroma
	// Entry value is chroma * 16 + luma
	// --------------------------------------------------------------------------
	localparam logic [5:0] InterCbp [48] = '{
		 0, 16,  1,  2,  4,  8, 32,  3,
		 5, 10, 12, 15, 47,  7, 11, 13,
		14,  6,  9, 31, 35, 37, 42, 44,
		33, 34, 36, 40, 39, 43, 45, 46,
		17, 18, 20, 24, 19, 21, 26, 28,
		23, 27, 29, 30, 22, 25, 38, 41
	};

	localparam logic [5:0] Intra4x4Cbp [48] = '{
		47, 31, 15,  0, 23, 27, 29, 30,
		 7, 11, 13, 14, 39, 43, 45, 46,
		16,  3,  5, 10, 12, 19, 21, 26,
		28, 35, 37, 42, 44,  1,  2,  4,
		 8, 17, 18, 20, 24,  6,  9, 22,
		25, 32, 33, 34, 36, 40, 38, 41
	};

	logic [5:0] lutVal;

	always_comb
	begin
		if (cbpCode > 6'(codecPkg::CbpCodeMax))
			lutVal = 6'd47;  // Everything coded
		else if (mbClass == codecPkg::mbInter)
			lutVal = InterCbp[cbpCode];
		else
			lutVal = Intra4x4Cbp[cbpCode];
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			cbpDone <= 1'b0;
		else
			cbpDone <= cbpValid;
	end

	always_ff @(posedge clk)
	begin
		if (cbpValid)
		begin
			cbp.luma   <= lutVal[3:0];
			cbp.chroma <= lutVal[5:4];
		end
	end

endmodule

`default_nettype wire

/* verilog/codecPkg.sv */
// Codec definitions for the macroblock header decoder
// Slice types, macroblock classes, coded block pattern and result payload

`default_nettype none

package codecPkg;

	// Slice kinds carried by the reduced header stream
	typedef enum logic
	{
		sliceP = 1'b0,
		sliceI = 1'b1
	} sliceTypeT;

	// Macroblock prediction class after mb_type sorting
	typedef enum logic [1:0]
	{
		mbInter      = 2'd0,
		mbIntra4x4   = 2'd1,
		mbIntra16x16 = 2'd2
	} mbClassT;

	// Coded block pattern split into its two parts
	typedef struct packed
	{
		logic [3:0] luma;    // One bit per 8x8 quadrant
		logic [1:0] chroma;  // 0 none, 1 DC only, 2 DC and AC
	} cbpT;

	// One decoded macroblock header
	typedef struct packed
	{
		logic [4:0] mbType;  // Raw slice-relative mb_type
		mbClassT    mbClass;
		cbpT        cbp;
		logic       error;
	} mbHeaderT;

	// --------------------------------------------------------------------------
	// Syntax limits of the reduced stream
	// --------------------------------------------------------------------------
	localparam int PIntraOffset = 5;   // P slice intra types start here
	localparam int I16TypeMax   = 24;  // Last intra 16x16 type
	localparam int CbpCodeMax   = 47;  // Last valid coded_block_pattern code

endpackage

`default_nettype wire

/* verilog/expGolombDecoder.sv */
// Unsigned Exp-Golomb decoder
// Counts the leading zeros, shifts in as many suffix bits and
// returns the code number one cycle after the last bit

`timescale 1ns/1ps
`default_nettype none

module expGolombDecoder #(
	parameter int MaxZeros = 15
) (
	input  wire logic          clk,
	input  wire logic          rstN,
	input  wire logic          bitValid,
	input  wire logic          bitData,
	output logic               bitTake,
	input  wire logic          codeReq,
	output logic               codeValid,
	output logic [MaxZeros:0]  codeNum,
	output logic               codeError
);

	localparam int CodeW = MaxZeros + 1;
	localparam int RunW  = $clog2(MaxZeros + 1);

	typedef enum logic [1:0]
	{
		stIdle,
		stZeros,
		stSuffix
	} stateT;

	stateT           state;
	logic [RunW-1:0] runCnt;   // Zeros seen, then suffix bits left
	logic [MaxZeros:0] acc;    // Leading one plus suffix so far
	logic            bitIn;

	assign bitTake = (state != stIdle);
	assign bitIn   = bitValid && bitTake;

	// --------------------------------------------------------------------------
	// Control
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= stIdle;
			runCnt    <= '0;
			codeValid <= 1'b0;
			codeError <= 1'b0;
		end
		else
		begin
			codeValid <= 1'b0;
			case (state)
				stIdle:
					if (codeReq)
					begin
						state  <= stZeros;
						runCnt <= '0;
					end
				stZeros:
					if (bitIn)
					begin
						if (!bitData && runCnt == RunW'(MaxZeros))
						begin
							// Zero run too long for the code width
							state     <= stIdle;
							codeValid <= 1'b1;
							codeError <= 1'b1;
						end
						else if (!bitData)
							runCnt <= runCnt + 1'b1;
						else if (runCnt == '0)
						begin
							state     <= stIdle;  // Single bit code
							codeValid <= 1'b1;
							codeError <= 1'b0;
						end
						else
							state <= stSuffix;
					end
				stSuffix:
					if (bitIn)
					begin
						runCnt <= runCnt - 1'b1;
						if (runCnt == RunW'(1))
						begin
							state     <= stIdle;
							codeValid <= 1'b1;
							codeError <= 1'b0;
						end
					end
				default: state <= stIdle;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk)
	begin
		if (bitIn && state == stZeros && bitData)
		begin
			acc     <= CodeW'(1);
			codeNum <= '0;  // Final only when the run was empty
		end
		else if (bitIn && state == stSuffix)
		begin
			acc     <= {acc[MaxZeros-1:0], bitData};
			codeNum <= {acc[MaxZeros-1:0], bitData} - CodeW'(1);
		end
	end

endmodule

`default_nettype wire

/* verilog/mbHeaderParser.sv */
// Macroblock header sequencer
// Reads mb_type, sorts it by class, fetches the pattern code when needed
// and presents one result per macroblock on a valid/ready stream

`timescale 1ns/1ps
`default_nettype none

module mbHeaderParser #(
	parameter int MaxZeros = 15
) (
	input  wire logic              clk,
	input  wire logic              rstN,
	input  codecPkg::sliceTypeT    sliceType,
	output logic                   codeReq,
	input  wire logic              codeValid,
	input  wire logic [MaxZeros:0] codeNum,
	input  wire logic              codeError,
	output logic                   cbpValid,
	output logic [5:0]             cbpCode,
	output codecPkg::mbClassT      mbClass,
	input  wire logic              cbpDone,
	input  codecPkg::cbpT          cbp,
	output codecPkg::mbHeaderT     resultData,
	output logic                   resultValid,
	input  wire logic              resultReady
);

	localparam int CodeW = MaxZeros + 1;

	typedef enum logic [2:0]
	{
		stReqType,
		stWaitType,
		stReqCbp,
		stWaitCbp,
		stLookup,
		stEmit
	} stateT;

	stateT              state;
	codecPkg::mbHeaderT resQ;
	logic               isInter;
	logic [MaxZeros:0]  intraType;  // mb_type in the I slice numbering
	logic [4:0]         k;          // Intra 16x16 index
	logic [2:0]         kq;
	logic [1:0]         chroma16;
	logic               patternDone;  // Table lookup finished
	codecPkg::cbpT      pattern;

	assign codeReq     = (state == stReqType) || (state == stReqCbp);
	assign resultValid = (state == stEmit);
	assign resultData  = resQ;
	assign mbClass     = resQ.mbClass;

	// --------------------------------------------------------------------------
	// mb_type sorting
	// --------------------------------------------------------------------------
	always_comb
	begin
		isInter   = (sliceType == codecPkg::sliceP) &&
			(codeNum < CodeW'(codecPkg::PIntraOffset));
		intraType = (sliceType == codecPkg::sliceP) ?
			codeNum - CodeW'(codecPkg::PIntraOffset) : codeNum;
		k         = intraType[4:0] - 5'd1;
		kq        = k[4:2];
		chroma16  = (kq >= 3'd3) ? 2'(kq - 3'd3) : kq[1:0];  // (k / 4) mod 3
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= stReqType;
			resQ     <= '0;
			cbpValid <= 1'b0;
			cbpCode  <= '0;
		end
		else
		begin
			cbpValid <= 1'b0;
			case (state)
				stReqType: state <= stWaitType;
				stWaitType:
					if (codeValid)
					begin
						resQ.mbType <= codeNum[4:0];
						resQ.error  <= 1'b0;
						if (codeError)
						begin
							resQ.error <= 1'b1;
							state      <= stEmit;
						end
						else if (isInter)
						begin
							resQ.mbClass <= codecPkg::mbInter;
							state        <= stReqCbp;
						end
						else if (intraType == '0)
						begin
							resQ.mbClass <= codecPkg::mbIntra4x4;
							state        <= stReqCbp;
						end
						else if (intraType <= CodeW'(codecPkg::I16TypeMax))
						begin
							// Pattern comes from mb_type itself
							resQ.mbClass    <= codecPkg::mbIntra16x16;
							resQ.cbp.luma   <= (k >= 5'd12) ? 4'hF : 4'h0;
							resQ.cbp.chroma <= chroma16;
							state           <= stEmit;
						end
						else
						begin
							resQ.error <= 1'b1;  // I_PCM or out of range
							state      <= stEmit;
						end
					end
				stReqCbp: state <= stWaitCbp;
				stWaitCbp:
					if (codeValid)
					begin
						if (codeError)
						begin
							resQ.error <= 1'b1;
							state      <= stEmit;
						end
						else
						begin
							cbpValid   <= 1'b1;
							cbpCode    <= (codeNum > CodeW'(63)) ? 6'd63 : codeNum[5:0];
							resQ.error <= (codeNum > CodeW'(codecPkg::CbpCodeMax));
							state      <= stLookup;
						end
					end
				stLookup:
					if (patternDone)
					begin
						resQ.cbp <= pattern;
						state    <= stEmit;
					end
				stEmit:
					if (resultReady)
						state <= stReqType;  // Hold until the transfer
				default: state <= stReqType;
			endcase
		end
	end

	cbpDecoder uCbpDecoder (
		.clk     (clk),
		.rstN    (rstN),
		.cbpValid(cbpValid),
		.cbpCode (cbpCode),
		.mbClass (mbClass),
		.cbpDone (patternDone),
		.cbp     (pattern)
	);

endmodule

`default_nettype wire

/* verilog/mbHeaderTop.sv */
// Macroblock header decoder top level
// Wishbone bitstream port, Exp-Golomb decoder and header parser

`timescale 1ns/1ps
`default_nettype none

module mbHeaderTop #(
	parameter int BufDepth = 4,
	parameter int MaxZeros = 15
) (
	input  wire logic           clk,
	input  wire logic           rstN,
	input  busPkg::wbReqT       wbReq,
	output busPkg::wbRspT       wbRsp,
	input  codecPkg::sliceTypeT sliceType,
	output codecPkg::mbHeaderT  resultData,
	output logic                resultValid,
	input  wire logic           resultReady
);

	logic              bitValid;
	logic              bitData;
	logic              bitTake;
	logic              codeReq;
	logic              codeValid;
	logic [MaxZeros:0] codeNum;
	logic              codeError;

	wbBitstreamPort #(.BufDepth(BufDepth)) uPort (
		.clk     (clk),
		.rstN    (rstN),
		.wbReq   (wbReq),
		.wbRsp   (wbRsp),
		.bitValid(bitValid),
		.bitData (bitData),
		.bitTake (bitTake)
	);

	expGolombDecoder #(.MaxZeros(MaxZeros)) uDecoder (
		.clk      (clk),
		.rstN     (rstN),
		.bitValid (bitValid),
		.bitData  (bitData),
		.bitTake  (bitTake),
		.codeReq  (codeReq),
		.codeValid(codeValid),
		.codeNum  (codeNum),
		.codeError(codeError)
	);

	mbHeaderParser #(.MaxZeros(MaxZeros)) uParser (
		.clk        (clk),
		.rstN       (rstN),
		.sliceType  (sliceType),
		.codeReq    (codeReq),
		.codeValid  (codeValid),
		.codeNum    (codeNum),
		.codeError  (codeError),
		.cbpValid   (),
		.cbpCode    (),
		.mbClass    (),
		.cbpDone    (),
		.cbp        (),
		.resultData (resultData),
		.resultValid(resultValid),
		.resultReady(resultReady)
	);

endmodule

`default_nettype wire

/* verilog/wbBitstreamPort.sv */
// Wishbone classic write port for bitstream words
// Buffers up to BufDepth words and hands them out one bit at a time, MSB first

`timescale 1ns/1ps
`default_nettype none

module wbBitstreamPort #(
	parameter int BufDepth = 4
) (
	input  wire logic          clk,
	input  wire logic          rstN,
	input  busPkg::wbReqT      wbReq,
	output busPkg::wbRspT      wbRsp,
	output logic               bitValid,
	output logic               bitData,
	input  wire logic          bitTake
);

	localparam int PtrW = $clog2(BufDepth);

	logic [31:0]     mem [BufDepth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0]   count;     // Words held
	logic [4:0]      bitIdx;    // Next bit of the head word
	logic            ack;
	logic            busReq;
	logic            wrEn;
	logic            headDone;

	assign busReq   = wbReq.cyc && wbReq.stb;
	assign wrEn     = ack && wbReq.we;  // Master still holds data in the ack cycle
	assign headDone = bitValid && bitTake && (bitIdx == 5'd0);

	assign wbRsp.ack = ack;
	assign wbRsp.dat = '0;  // Reads return zero

	assign bitValid = (count != '0);
	assign bitData  = mem[rdPtr][bitIdx];

	// --------------------------------------------------------------------------
	// Bus handshake
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			ack <= 1'b0;
		else
			ack <= busReq && !ack && (!wbReq.we || count != (PtrW + 1)'(BufDepth));
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= wbReq.dat;
	end

	// Pointers, fill level and bit position
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			bitIdx <= 5'd31;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (bitValid && bitTake)
				bitIdx <= bitIdx - 5'd1;  // Wraps to 31 for the next word
			if (headDone)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, headDone})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire
